// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= perceptron_tb
FILELIST ?= perceptron_node.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

PASS_TEXT := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/perceptron_fixed_pkg.sv ====
// fixed Q8.24 only; every operand and result is one signed 32-bit word, no other formats
package perceptron_fixed_pkg;

	//////////////////////////////
	// word format
	//////////////////////////////

	// width of every operand, product and result word
	localparam int fix_width = 32;

	// fraction bits leaving 8 integer bits including sign
	localparam int fix_frac = 24;

	// full multiplier output before rescale
	localparam int fix_prod_width = 2 * fix_width;

	// one Q8.24 word that is always signed
	typedef logic signed [fix_width-1:0] fix_t;

	//////////////////////////////
	// limits and constants
	//////////////////////////////

	// saturation limits of about +127.99999994 and -128.0
	localparam fix_t fix_max = 32'sh7fff_ffff;
	localparam fix_t fix_min = 32'sh8000_0000;

	// 1.0 in Q8.24
	// high output of the step activation
	localparam fix_t fix_one = 32'sh0100_0000;

endpackage

// ==== common/perceptron_regs_pkg.sv ====
// byte offsets on an 8-bit APB address; input and weight tables hold at most max_num words
package perceptron_regs_pkg;

	// APB address width seen by the node
	localparam int addr_width = 8;

	//////////////////////////////
	// register offsets
	//////////////////////////////

	localparam logic [addr_width-1:0] addr_ctrl = 8'h00;
	localparam logic [addr_width-1:0] addr_status = 8'h04;
	localparam logic [addr_width-1:0] addr_bias = 8'h08;
	localparam logic [addr_width-1:0] addr_result = 8'h0C;
	localparam logic [addr_width-1:0] addr_count = 8'h10;

	// tables with entry i at base + 4*i
	localparam logic [addr_width-1:0] addr_input_base = 8'h40;
	localparam logic [addr_width-1:0] addr_weight_base = 8'h80;

	// largest table the map has room for
	localparam int max_num = 16;

	//////////////////////////////
	// field positions
	//////////////////////////////

	// ctrl fields; start is write-one and reads back zero
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_act_lsb = 1;
	localparam int ctrl_act_msb = 2;

	// status fields
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;

	// activation select where code 3 falls back to identity
	typedef logic [1:0] act_t;
	localparam act_t act_identity = 2'd0;
	localparam act_t act_relu = 2'd1;
	localparam act_t act_step = 2'd2;

endpackage

// ==== dv/perceptron_model.svh ====
// model for NUM = 2 only; APB tasks leave the bus in the access phase until the next transfer
`ifndef perceptron_model_svh
`define perceptron_model_svh

	//////////////////////////////
	// arithmetic model
	//////////////////////////////

	// clamp a wide value to the 32-bit signed range
	function automatic logic [31:0] sat32(input longint v);
		if (v > longint'(perceptron_fixed_pkg::fix_max))
			return perceptron_fixed_pkg::fix_max;
		if (v < longint'(perceptron_fixed_pkg::fix_min))
			return perceptron_fixed_pkg::fix_min;
		return v[31:0];
	endfunction

	// full product then floor by 24 fraction bits
	function automatic logic [31:0] model_mul(input logic [31:0] a, input logic [31:0] b);
		longint prod;
		prod = longint'($signed(a)) * longint'($signed(b));
		return sat32(prod >>> perceptron_fixed_pkg::fix_frac);
	endfunction

	function automatic logic [31:0] model_sum(input logic [31:0] p0, input logic [31:0] p1,
			input logic [31:0] bias);
		longint total;
		total = longint'($signed(p0)) + longint'($signed(p1)) + longint'($signed(bias));
		return sat32(total);
	endfunction

	// code 3 falls through to identity
	function automatic logic [31:0] model_act(input logic [31:0] sum, input logic [1:0] act);
		case (act)
			perceptron_regs_pkg::act_relu:
				return ($signed(sum) < 0) ? 32'd0 : sum;
			perceptron_regs_pkg::act_step:
				return ($signed(sum) < 0) ? 32'd0 : perceptron_fixed_pkg::fix_one;
			default:
				return sum;
		endcase
	endfunction

	function automatic logic [31:0] model_eval(input logic [31:0] in0, input logic [31:0] in1,
			input logic [31:0] w0, input logic [31:0] w1, input logic [31:0] bias,
			input logic [1:0] act);
		return model_act(model_sum(model_mul(in0, w0), model_mul(in1, w1), bias), act);
	endfunction

	//////////////////////////////
	// random source
	//////////////////////////////

	// Galois form with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit taken with the msb first
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return r;
	endfunction

	// 28 random bits sign-extended to about +-8.0
	function automatic logic [31:0] rand_fix();
		logic [31:0] r;
		r = rand_bits(28);
		return {{4{r[27]}}, r[27:0]};
	endfunction

	//////////////////////////////
	// APB transfers
	//////////////////////////////

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
			input logic expect_err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		// middle of the access phase
		@(negedge clk);
		if (pready !== 1'b1) begin
			errors++;
			$display("** Error at %0t: pready = %b, expected 1", $time, pready);
		end
		if (pslverr !== expect_err) begin
			errors++;
			$display("APB write to offset %h at %0t: pslverr %s", addr, $time,
				expect_err ? "missing" : "raised unexpectedly");
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
			input logic expect_err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		if (pready !== 1'b1) begin
			errors++;
			$display("** Error at %0t: pready = %b, expected 1", $time, pready);
		end
		if (pslverr !== expect_err) begin
			errors++;
			$display("APB read of offset %h at %0t: pslverr %s", addr, $time,
				expect_err ? "missing" : "raised unexpectedly");
		end
	endtask

	task automatic bus_idle();
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

`endif

// ==== dv/perceptron_tb.sv ====
// runs with NUM = 2 only; hand rows, then 20 LFSR rows, then pipelining, address and latency tests
`timescale 1ns/1ps

module perceptron_tb;

	localparam int num = 2;
	localparam int n_hand = 12;
	localparam int n_rand = 20;
	// a row takes about 20 cycles, so 40 leaves headroom
	localparam int cycle_limit = (n_hand + n_rand) * 40 + 200;

	logic clk;
	logic rst;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	int errors;
	int checks;
	int exp_count;
	int cycles = 0;
	logic [31:0] lfsr_state;

	// last values written for the untouched-register checks
	logic [31:0] cur_in [num];
	logic [31:0] cur_w [num];
	logic [31:0] cur_bias;

	// columns are in0, in1, w0, w1, bias, act and expected
	localparam logic [31:0] hand_tbl [n_hand][7] = '{
		// 0.75 - 0.5 + 0.25
		'{32'h0180_0000, 32'h0200_0000, 32'h0080_0000, 32'hffc0_0000,
			32'h0040_0000, 32'd0, 32'h0080_0000},
		// relu of -1.5
		'{32'h0100_0000, 32'h0100_0000, 32'hfe00_0000, 32'h0080_0000,
			32'h0000_0000, 32'd1, 32'h0000_0000},
		// relu of 2.5
		'{32'h0300_0000, 32'h0100_0000, 32'h0100_0000, 32'h0080_0000,
			32'hff00_0000, 32'd1, 32'h0280_0000},
		// step at exactly zero
		'{32'h0100_0000, 32'h0200_0000, 32'h0100_0000, 32'hff80_0000,
			32'h0000_0000, 32'd2, 32'h0100_0000},
		// step of -0.25
		'{32'h0100_0000, 32'h0000_0000, 32'hffc0_0000, 32'h0000_0000,
			32'h0000_0000, 32'd2, 32'h0000_0000},
		// half an lsb floors to 0 and to -1
		'{32'h0000_0001, 32'hffff_ffff, 32'h0080_0000, 32'h0080_0000,
			32'h0000_0000, 32'd0, 32'hffff_ffff},
		// 1.5 lsb floors to 1 and -1.5 lsb to -2, plus 16
		'{32'h0000_0003, 32'hffff_fffd, 32'h0080_0000, 32'h0080_0000,
			32'h0000_0010, 32'd0, 32'h0000_000f},
		// 127 * 2 clamps high in the multiplier
		'{32'h7f00_0000, 32'h0000_0000, 32'h0200_0000, 32'h0000_0000,
			32'h0000_0000, 32'd0, 32'h7fff_ffff},
		// 127 * -2 clamps low
		'{32'h7f00_0000, 32'h0000_0000, 32'hfe00_0000, 32'h0000_0000,
			32'h0000_0000, 32'd0, 32'h8000_0000},
		// 100 + 100 clamps in the sum
		'{32'h6400_0000, 32'h6400_0000, 32'h0100_0000, 32'h0100_0000,
			32'h0000_0000, 32'd1, 32'h7fff_ffff},
		// -100 - 100 - 1
		'{32'h9c00_0000, 32'h9c00_0000, 32'h0100_0000, 32'h0100_0000,
			32'hff00_0000, 32'd0, 32'h8000_0000},
		// code 3 acts as identity
		'{32'h0080_0000, 32'h0000_0000, 32'h0080_0000, 32'h0000_0000,
			32'h0000_0000, 32'd3, 32'h0040_0000}
	};

	`include "perceptron_model.svh"

	perceptron_node #(
		.NUM (num)
	) i_perceptron_node (
		.clk     (clk),
		.rst     (rst),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #5 clk = ~clk;

	// run guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout at cycle %0d, the tests did not finish", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic load_operands(input logic [31:0] in0, input logic [31:0] in1,
			input logic [31:0] w0, input logic [31:0] w1, input logic [31:0] bias);
		apb_write(perceptron_regs_pkg::addr_input_base, in0, 1'b0);
		apb_write(perceptron_regs_pkg::addr_input_base + 8'd4, in1, 1'b0);
		apb_write(perceptron_regs_pkg::addr_weight_base, w0, 1'b0);
		apb_write(perceptron_regs_pkg::addr_weight_base + 8'd4, w1, 1'b0);
		apb_write(perceptron_regs_pkg::addr_bias, bias, 1'b0);
		cur_in[0] = in0;
		cur_in[1] = in1;
		cur_w[0] = w0;
		cur_w[1] = w1;
		cur_bias = bias;
	endtask

	task automatic start_eval(input logic [1:0] act);
		apb_write(perceptron_regs_pkg::addr_ctrl, {29'd0, act, 1'b1}, 1'b0);
		exp_count++;
	endtask

	// poll status until done is set
	task automatic wait_done();
		logic [31:0] st;
		apb_read(perceptron_regs_pkg::addr_status, st, 1'b0);
		while (!st[perceptron_regs_pkg::status_done_bit])
			apb_read(perceptron_regs_pkg::addr_status, st, 1'b0);
	endtask

	task automatic run_row(input string tag, input logic [31:0] in0, input logic [31:0] in1,
			input logic [31:0] w0, input logic [31:0] w1, input logic [31:0] bias,
			input logic [1:0] act, input logic [31:0] exp);
		logic [31:0] data;
		load_operands(in0, in1, w0, w1, bias);
		start_eval(act);
		wait_done();
		apb_read(perceptron_regs_pkg::addr_result, data, 1'b0);
		check_eq({"result ", tag}, data, exp);
		apb_read(perceptron_regs_pkg::addr_count, data, 1'b0);
		check_eq({"count ", tag}, data, exp_count);
	endtask

	initial begin
		logic [31:0] data;
		logic [31:0] exp;
		logic [31:0] r_in0;
		logic [31:0] r_in1;
		logic [31:0] r_w0;
		logic [31:0] r_w1;
		logic [31:0] r_bias;
		logic [1:0] r_act;

		clk = 1'b0;
		rst = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		lfsr_state = 32'hfb88;
		errors = 0;
		checks = 0;
		exp_count = 0;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		////////////////////////////// reset state
		apb_read(perceptron_regs_pkg::addr_status, data, 1'b0);
		check_eq("status after reset", data, 32'd0);
		apb_read(perceptron_regs_pkg::addr_result, data, 1'b0);
		check_eq("result after reset", data, 32'd0);
		apb_read(perceptron_regs_pkg::addr_count, data, 1'b0);
		check_eq("count after reset", data, 32'd0);

		////////////////////////////// hand table also cross-checked against the model
		for (int r = 0; r < n_hand; r++) begin
			exp = model_eval(hand_tbl[r][0], hand_tbl[r][1], hand_tbl[r][2], hand_tbl[r][3],
				hand_tbl[r][4], hand_tbl[r][5][1:0]);
			check_eq($sformatf("model on hand row %0d", r), exp, hand_tbl[r][6]);
			run_row($sformatf("hand row %0d", r), hand_tbl[r][0], hand_tbl[r][1],
				hand_tbl[r][2], hand_tbl[r][3], hand_tbl[r][4], hand_tbl[r][5][1:0],
				hand_tbl[r][6]);
		end

		// random rows with expected values from the model
		for (int r = 0; r < n_rand; r++) begin
			r_in0 = rand_fix();
			r_in1 = rand_fix();
			r_w0 = rand_fix();
			r_w1 = rand_fix();
			r_bias = rand_fix();
			r_act = 2'(rand_bits(2));
			exp = model_eval(r_in0, r_in1, r_w0, r_w1, r_bias, r_act);
			run_row($sformatf("random row %0d", r), r_in0, r_in1, r_w0, r_w1, r_bias, r_act, exp);
		end

		////////////////////////////// back-to-back starts
		// sum is 0.5, so the last start under step gives 1.0
		load_operands(32'h0100_0000, 32'h0200_0000, 32'hff00_0000, 32'h00c0_0000, 32'h0000_0000);
		start_eval(perceptron_regs_pkg::act_identity);
		start_eval(perceptron_regs_pkg::act_relu);
		start_eval(perceptron_regs_pkg::act_step);
		bus_idle();
		wait_done();
		apb_read(perceptron_regs_pkg::addr_count, data, 1'b0);
		check_eq("count after three starts", data, exp_count);
		apb_read(perceptron_regs_pkg::addr_result, data, 1'b0);
		check_eq("result after three starts", data, model_eval(cur_in[0], cur_in[1], cur_w[0],
			cur_w[1], cur_bias, perceptron_regs_pkg::act_step));

		////////////////////////////// address errors
		apb_write(8'h20, 32'hdead_beef, 1'b1);
		apb_read(8'h20, data, 1'b1);
		check_eq("read of unmapped offset", data, 32'd0);
		apb_write(perceptron_regs_pkg::addr_input_base + 8'd8, 32'h1234_5678, 1'b1);
		apb_read(perceptron_regs_pkg::addr_input_base + 8'd8, data, 1'b1);
		check_eq("read of input 2", data, 32'd0);
		apb_write(perceptron_regs_pkg::addr_weight_base + 8'd8, 32'h1234_5678, 1'b1);
		// nothing in the map moved
		for (int i = 0; i < num; i++) begin
			apb_read(perceptron_regs_pkg::addr_input_base + 8'(4 * i), data, 1'b0);
			check_eq($sformatf("input %0d after bad writes", i), data, cur_in[i]);
			apb_read(perceptron_regs_pkg::addr_weight_base + 8'(4 * i), data, 1'b0);
			check_eq($sformatf("weight %0d after bad writes", i), data, cur_w[i]);
		end
		apb_read(perceptron_regs_pkg::addr_bias, data, 1'b0);
		check_eq("bias after bad writes", data, cur_bias);
		apb_read(perceptron_regs_pkg::addr_count, data, 1'b0);
		check_eq("count after bad writes", data, exp_count);

		////////////////////////////// fixed latency
		// start access, one idle cycle, setup, then the read access lands 3 cycles on
		load_operands(32'h0200_0000, 32'h0300_0000, 32'h0100_0000, 32'h0100_0000, 32'h0000_0000);
		start_eval(perceptron_regs_pkg::act_identity);
		bus_idle();
		apb_read(perceptron_regs_pkg::addr_result, data, 1'b0);
		check_eq("result 3 cycles after start", data, model_eval(cur_in[0], cur_in[1], cur_w[0],
			cur_w[1], cur_bias, perceptron_regs_pkg::act_identity));
		wait_done();
		bus_idle();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== perceptron/fixed_mul_sat.sv ====
// Q8.24 only; rescale floors toward minus infinity, then clamps to the 32-bit signed range
`timescale 1ns/1ps

module fixed_mul_sat (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       en,
	input  perceptron_fixed_pkg::fix_t a,
	input  perceptron_fixed_pkg::fix_t b,
	output perceptron_fixed_pkg::fix_t p
);

	logic signed [perceptron_fixed_pkg::fix_prod_width-1:0] prod_full;
	logic signed [perceptron_fixed_pkg::fix_prod_width-1:0] prod_shift;
	perceptron_fixed_pkg::fix_t prod_sat;

	//////////////////////////////
	// multiply and rescale
	//////////////////////////////

	// full signed product as Q16.48 in 64 bits
	assign prod_full = a * b;

	// drop 24 fraction bits
	// arithmetic shift floors negative values
	assign prod_shift = prod_full >>> perceptron_fixed_pkg::fix_frac;

	//////////////////////////////
	// saturate
	//////////////////////////////

	always_comb begin
		// compare in 64 bits where the limits sign-extend
		if (prod_shift > perceptron_fixed_pkg::fix_max)
			prod_sat = perceptron_fixed_pkg::fix_max;
		else if (prod_shift < perceptron_fixed_pkg::fix_min)
			prod_sat = perceptron_fixed_pkg::fix_min;
		else
			prod_sat = prod_shift[perceptron_fixed_pkg::fix_width-1:0];
	end

	// product shows up one cycle after en
	// holds while en is low
	always_ff @(posedge clk) begin
		if (rst)
			p <= '0;
		else if (en)
			p <= prod_sat;
	end

endmodule

// ==== perceptron/perceptron.sv ====
// fixed 3-cycle latency, a start every cycle accepted; no back-pressure, NUM from 1 to 16
`timescale 1ns/1ps

module perceptron #(
	parameter int NUM = 2
) (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           start,
	input  logic [NUM*perceptron_fixed_pkg::fix_width-1:0] inputs,
	input  logic [NUM*perceptron_fixed_pkg::fix_width-1:0] weights,
	input  perceptron_fixed_pkg::fix_t                     bias,
	input  perceptron_regs_pkg::act_t                      act,
	output logic                                           valid,
	output perceptron_fixed_pkg::fix_t                     result
);

	localparam int fw = perceptron_fixed_pkg::fix_width;

	// room for NUM products plus bias without overflow
	localparam int acc_w = fw + $clog2(NUM + 1);

	perceptron_fixed_pkg::fix_t prod [NUM];

	// stage 1 side band
	perceptron_fixed_pkg::fix_t bias_s1;
	perceptron_regs_pkg::act_t act_s1;
	logic v1;

	// stage 2
	perceptron_fixed_pkg::fix_t sum_s2;
	perceptron_regs_pkg::act_t act_s2;
	logic v2;

	logic signed [acc_w-1:0] acc;
	perceptron_fixed_pkg::fix_t sum_sat;
	perceptron_fixed_pkg::fix_t act_out;

	//////////////////////////////
	// stage 1 products
	//////////////////////////////

	// one multiplier per input, all loaded on start
	for (genvar i = 0; i < NUM; i++) begin : g_mul
		fixed_mul_sat i_fixed_mul_sat (
			.clk (clk),
			.rst (rst),
			.en  (start),
			.a   (inputs[i*fw +: fw]),
			.b   (weights[i*fw +: fw]),
			.p   (prod[i])
		);
	end

	// bias and select travel beside the products
	always_ff @(posedge clk) begin
		if (start) begin
			bias_s1 <= bias;
			act_s1 <= act;
		end
	end

	//////////////////////////////
	// stage 2 sum and bias
	//////////////////////////////

	always_comb begin
		// signed terms sign-extend into the wide accumulator
		acc = bias_s1;
		for (int i = 0; i < NUM; i++)
			acc = acc + prod[i];
		if (acc > perceptron_fixed_pkg::fix_max)
			sum_sat = perceptron_fixed_pkg::fix_max;
		else if (acc < perceptron_fixed_pkg::fix_min)
			sum_sat = perceptron_fixed_pkg::fix_min;
		else
			sum_sat = acc[fw-1:0];
	end

	always_ff @(posedge clk) begin
		if (v1) begin
			sum_s2 <= sum_sat;
			act_s2 <= act_s1;
		end
	end

	//////////////////////////////
	// stage 3 activation
	//////////////////////////////

	always_comb begin
		case (act_s2)
			perceptron_regs_pkg::act_relu:
				act_out = (sum_s2 < 0) ? '0 : sum_s2;
			perceptron_regs_pkg::act_step:
				act_out = (sum_s2 < 0) ? '0 : perceptron_fixed_pkg::fix_one;
			// identity and the unused code 3
			default:
				act_out = sum_s2;
		endcase
	end

	always_ff @(posedge clk) begin
		if (v2)
			result <= act_out;
	end

	// valid bits run beside the data stages
	always_ff @(posedge clk) begin
		if (rst) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			valid <= 1'b0;
		end else begin
			v1 <= start;
			v2 <= v1;
			valid <= v2;
		end
	end

endmodule

// ==== perceptron_node.f ====
+incdir+dv
common/perceptron_fixed_pkg.sv
common/perceptron_regs_pkg.sv
perceptron/fixed_mul_sat.sv
perceptron/perceptron.sv
rtl/perceptron_apb_regs.sv
rtl/perceptron_node.sv
dv/perceptron_tb.sv

// ==== rtl/perceptron_apb_regs.sv ====
// APB slave without wait states; NUM at most 16; unaligned or unmapped offsets give pslverr
`timescale 1ns/1ps

module perceptron_apb_regs #(
	parameter int NUM = 2
) (
	input  logic                                            clk,
	input  logic                                            rst,
	input  logic [perceptron_regs_pkg::addr_width-1:0]      paddr,
	input  logic                                            psel,
	input  logic                                            penable,
	input  logic                                            pwrite,
	input  logic [31:0]                                     pwdata,
	output logic [31:0]                                     prdata,
	output logic                                            pready,
	output logic                                            pslverr,
	output logic                                            start,
	output logic [NUM*perceptron_fixed_pkg::fix_width-1:0]  inputs,
	output logic [NUM*perceptron_fixed_pkg::fix_width-1:0]  weights,
	output perceptron_fixed_pkg::fix_t                      bias,
	output perceptron_regs_pkg::act_t                       act,
	input  logic                                            valid,
	input  perceptron_fixed_pkg::fix_t                      result
);

	// table index bits from paddr[idx_w+1:2]
	localparam int idx_w = $clog2(perceptron_regs_pkg::max_num);
	localparam int aw = perceptron_regs_pkg::addr_width;

	logic [NUM-1:0][perceptron_fixed_pkg::fix_width-1:0] input_q;
	logic [NUM-1:0][perceptron_fixed_pkg::fix_width-1:0] weight_q;
	perceptron_fixed_pkg::fix_t bias_q;
	perceptron_fixed_pkg::fix_t result_q;
	perceptron_regs_pkg::act_t act_q;
	logic [31:0] count_q;
	logic [1:0] inflight_q;
	logic [1:0] inflight_nxt;
	logic done_q;
	logic busy;

	logic access;
	logic wr_en;
	logic rd_en;
	logic [idx_w-1:0] idx;
	logic in_hit;
	logic wt_hit;
	logic reg_hit;
	logic addr_ok;
	logic ctrl_wr;
	logic [31:0] rdata;

	//////////////////////////////
	// address decode
	//////////////////////////////

	assign access = psel & penable;
	assign wr_en = access & pwrite;
	assign rd_en = access & ~pwrite;
	assign idx = paddr[idx_w+1:2];

	always_comb begin
		// tables sit in their own aligned windows above the scalar registers
		in_hit = (paddr[aw-1:idx_w+2] == perceptron_regs_pkg::addr_input_base[aw-1:idx_w+2])
			&& (paddr[1:0] == 2'b00) && (int'(idx) < NUM);
		wt_hit = (paddr[aw-1:idx_w+2] == perceptron_regs_pkg::addr_weight_base[aw-1:idx_w+2])
			&& (paddr[1:0] == 2'b00) && (int'(idx) < NUM);
		reg_hit = (paddr == perceptron_regs_pkg::addr_ctrl)
			|| (paddr == perceptron_regs_pkg::addr_status)
			|| (paddr == perceptron_regs_pkg::addr_bias)
			|| (paddr == perceptron_regs_pkg::addr_result)
			|| (paddr == perceptron_regs_pkg::addr_count);
		addr_ok = in_hit | wt_hit | reg_hit;
	end

	// never stalls
	assign pready = 1'b1;
	assign pslverr = access & ~addr_ok;

	assign ctrl_wr = wr_en && (paddr == perceptron_regs_pkg::addr_ctrl);

	// one-cycle start on the access cycle of a ctrl write with bit 0 set
	assign start = ctrl_wr & pwdata[perceptron_regs_pkg::ctrl_start_bit];

	//////////////////////////////
	// operands to the datapath
	//////////////////////////////

	assign inputs = input_q;
	assign weights = weight_q;
	assign bias = bias_q;

	// select written together with start takes effect for that start
	assign act = ctrl_wr
		? pwdata[perceptron_regs_pkg::ctrl_act_msb:perceptron_regs_pkg::ctrl_act_lsb]
		: act_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			input_q <= '0;
			weight_q <= '0;
			bias_q <= '0;
			act_q <= perceptron_regs_pkg::act_identity;
		end else if (wr_en) begin
			if (in_hit)
				input_q[idx] <= pwdata;
			if (wt_hit)
				weight_q[idx] <= pwdata;
			if (paddr == perceptron_regs_pkg::addr_bias)
				bias_q <= pwdata;
			if (ctrl_wr)
				act_q <= act;
		end
	end

	//////////////////////////////
	// status, result and count
	//////////////////////////////

	// at most three evaluations in flight with a 3-deep pipeline
	always_comb begin
		case ({start, valid})
			2'b10:   inflight_nxt = inflight_q + 2'd1;
			2'b01:   inflight_nxt = inflight_q - 2'd1;
			default: inflight_nxt = inflight_q;
		endcase
	end

	assign busy = (inflight_q != 2'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			inflight_q <= '0;
			done_q <= 1'b0;
			result_q <= '0;
			count_q <= '0;
		end else begin
			inflight_q <= inflight_nxt;
			// done means the last started evaluation has landed
			if (start)
				done_q <= 1'b0;
			else if (valid && (inflight_nxt == 2'd0))
				done_q <= 1'b1;
			if (valid) begin
				result_q <= result;
				count_q <= count_q + 32'd1;
			end
		end
	end

	//////////////////////////////
	// read mux
	//////////////////////////////

	always_comb begin
		rdata = '0;
		if (in_hit) begin
			rdata = input_q[idx];
		end else if (wt_hit) begin
			rdata = weight_q[idx];
		end else begin
			case (paddr)
				perceptron_regs_pkg::addr_ctrl:
					rdata[perceptron_regs_pkg::ctrl_act_msb:perceptron_regs_pkg::ctrl_act_lsb] = act_q;
				perceptron_regs_pkg::addr_status: begin
					rdata[perceptron_regs_pkg::status_busy_bit] = busy;
					rdata[perceptron_regs_pkg::status_done_bit] = done_q;
				end
				perceptron_regs_pkg::addr_bias:
					rdata = bias_q;
				// a result arriving this cycle is forwarded to the reader
				perceptron_regs_pkg::addr_result:
					rdata = valid ? result : result_q;
				perceptron_regs_pkg::addr_count:
					rdata = count_q;
				default:
					rdata = '0;
			endcase
		end
	end

	// bus reads zero outside a good read access
	assign prdata = (rd_en && addr_ok) ? rdata : 32'd0;

endmodule

// ==== rtl/perceptron_node.sv ====
// APB-mapped perceptron; NUM from 1 to 16, result register updates 3 cycles after start
`timescale 1ns/1ps

module perceptron_node #(
	parameter int NUM = 2
) (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic [perceptron_regs_pkg::addr_width-1:0] paddr,
	input  logic                                       psel,
	input  logic                                       penable,
	input  logic                                       pwrite,
	input  logic [31:0]                                pwdata,
	output logic [31:0]                                prdata,
	output logic                                       pready,
	output logic                                       pslverr
);

	// operands that the datapath snapshots on start
	logic start;
	logic [NUM*perceptron_fixed_pkg::fix_width-1:0] inputs;
	logic [NUM*perceptron_fixed_pkg::fix_width-1:0] weights;
	perceptron_fixed_pkg::fix_t bias;
	perceptron_regs_pkg::act_t act;

	// result path back to the registers
	logic valid;
	perceptron_fixed_pkg::fix_t result;

	//////////////////////////////
	// register block
	//////////////////////////////

	perceptron_apb_regs #(
		.NUM (NUM)
	) i_perceptron_apb_regs (
		.clk     (clk),
		.rst     (rst),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.start   (start),
		.inputs  (inputs),
		.weights (weights),
		.bias    (bias),
		.act     (act),
		.valid   (valid),
		.result  (result)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////

	perceptron #(
		.NUM (NUM)
	) i_perceptron (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.inputs  (inputs),
		.weights (weights),
		.bias    (bias),
		.act     (act),
		.valid   (valid),
		.result  (result)
	);

endmodule
